/* tscPkg.sv */
package tscPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Machine size
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int WordWidth = 16;
    localparam int NumRegs   = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [3:0] BneOp   = 4'd0;
    localparam logic [3:0] BeqOp   = 4'd1;
    localparam logic [3:0] BgzOp   = 4'd2;
    localparam logic [3:0] BlzOp   = 4'd3;
    localparam logic [3:0] AdiOp   = 4'd4;
    localparam logic [3:0] OriOp   = 4'd5;
    localparam logic [3:0] LwdOp   = 4'd7;
    localparam logic [3:0] SwdOp   = 4'd8;
    localparam logic [3:0] JalOp   = 4'd10;
    localparam logic [3:0] RtypeOp = 4'd15;  // ALU ops, WWD and JRL share this

    // Function codes of the register format
    localparam logic [5:0] FuncAdd = 6'd0;
    localparam logic [5:0] FuncSub = 6'd1;
    localparam logic [5:0] FuncAnd = 6'd2;
    localparam logic [5:0] FuncOrr = 6'd3;
    localparam logic [5:0] FuncNot = 6'd4;
    localparam logic [5:0] FuncTcp = 6'd5;
    localparam logic [5:0] FuncShl = 6'd6;
    localparam logic [5:0] FuncShr = 6'd7;   // Highest ALU function code
    localparam logic [5:0] FuncJrl = 6'd26;
    localparam logic [5:0] FuncWwd = 6'd28;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU operation codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [3:0] AluAdd  = 4'd0;
    localparam logic [3:0] AluSub  = 4'd1;
    localparam logic [3:0] AluAnd  = 4'd2;
    localparam logic [3:0] AluOr   = 4'd3;
    localparam logic [3:0] AluNot  = 4'd4;
    localparam logic [3:0] AluTcp  = 4'd5;   // Two's complement negate
    localparam logic [3:0] AluAls  = 4'd6;
    localparam logic [3:0] AluArs  = 4'd7;
    localparam logic [3:0] AluZero = 4'd8;

    // One instruction word, seen as R-format or as I-format
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rs;
            logic [1:0] rt;
            logic [1:0] rd;
            logic [5:0] func;
        } r;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rs;
            logic [1:0] rt;
            logic [7:0] imm;
        } i;
    } instrT;

endpackage

/* aluControl.sv */
`timescale 1ns/1ps

module aluControl (
    input  logic       isAlu,
    input  logic [3:0] opcode,
    input  logic [5:0] func,
    output logic [3:0] aluOp
);

    import tscPkg::*;

    always_comb begin
        if (isAlu) begin
            case (func)
                FuncAdd: aluOp = AluAdd;
                FuncSub: aluOp = AluSub;
                FuncAnd: aluOp = AluAnd;
                FuncOrr: aluOp = AluOr;
                FuncNot: aluOp = AluNot;
                FuncTcp: aluOp = AluTcp;
                FuncShl: aluOp = AluAls;
                FuncShr: aluOp = AluArs;
                default: aluOp = AluZero;
            endcase
        end else if (opcode == RtypeOp && (func == FuncWwd || func == FuncJrl)) begin
            aluOp = AluAdd;                      // WWD passes rs, JRL keeps its add
        end else begin
            case (opcode)
                AdiOp,
                LwdOp,
                SwdOp,
                BgzOp,
                BlzOp,
                JalOp:   aluOp = AluAdd;
                OriOp:   aluOp = AluOr;
                BneOp,
                BeqOp:   aluOp = AluSub;         // Compare by difference
                default: aluOp = AluZero;
            endcase
        end
    end

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  tscPkg::instrT instr,
    output logic [1:0]    rs,
    output logic [1:0]    rt,
    output logic [1:0]    wAddr,
    output logic          regWe,
    output logic          isAlu,
    output logic          useImm,
    output logic          signExtImm,
    output logic          isWwd,
    output logic          isLoad,
    output logic          isStore,
    output logic          isBranch,
    output logic [3:0]    opcode,
    output logic [5:0]    func,
    output logic [7:0]    imm
);

    import tscPkg::*;

    logic isRtype;
    logic isAdi;
    logic isOri;

    // Fields common to both formats come from the R view
    assign opcode = instr.r.opcode;
    assign rs     = instr.r.rs;
    assign rt     = instr.r.rt;
    assign func   = instr.r.func;
    assign imm    = instr.i.imm;             // Same bits as rd and func

    assign isRtype = (opcode == RtypeOp);
    assign isAdi   = (opcode == AdiOp);
    assign isOri   = (opcode == OriOp);

    assign isAlu    = isRtype && (func <= FuncShr);
    assign isWwd    = isRtype && (func == FuncWwd);
    assign isLoad   = (opcode == LwdOp);
    assign isStore  = (opcode == SwdOp);
    assign isBranch = (opcode == BneOp) || (opcode == BeqOp) ||
                      (opcode == BgzOp) || (opcode == BlzOp);

    assign useImm     = isAdi || isOri || isLoad || isStore;
    assign signExtImm = isAdi || isLoad || isStore;  // ORI alone zero-extends

    // R-format writes rd, the immediate forms write rt
    assign regWe = isAlu || isAdi || isOri;
    assign wAddr = isAlu ? instr.r.rd : instr.i.rt;

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [tscPkg::WordWidth-1:0] a,
    input  logic [tscPkg::WordWidth-1:0] b,
    input  logic [3:0]                   aluOp,
    output logic [tscPkg::WordWidth-1:0] y,
    output logic                         zero
);

    import tscPkg::*;

    logic [WordWidth-1:0] sum;
    logic [WordWidth-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (aluOp)
            AluAdd: begin
                y = sum;
            end
            AluSub: begin
                y = diff;
            end
            AluAnd: begin
                y = a & b;
            end
            AluOr: begin
                y = a | b;
            end
            AluNot: begin
                y = ~a;
            end
            AluTcp: begin
                y = ~a + {{(WordWidth-1){1'b0}}, 1'b1};
            end
            AluAls: begin
                y = {a[WordWidth-2:0], 1'b0};           // Same bits as a logical shift
            end
            AluArs: begin
                y = {a[WordWidth-1], a[WordWidth-1:1]}; // Sign bit is kept
            end
            default: begin
                y = '0;
            end
        endcase
    end

    assign zero = (y == '0);

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         we,
    input  logic [1:0]                   rAddr1,
    input  logic [1:0]                   rAddr2,
    input  logic [1:0]                   wAddr,
    input  logic [tscPkg::WordWidth-1:0] wData,
    output logic [tscPkg::WordWidth-1:0] rData1,
    output logic [tscPkg::WordWidth-1:0] rData2
);

    import tscPkg::*;

    logic [WordWidth-1:0] regs [NumRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < NumRegs; k++) begin
                regs[k] <= '0;
            end
        end else if (we) begin
            regs[wAddr] <= wData;
        end
    end

    // A write still on its way from the execute stage is forwarded to the readers
    assign rData1 = (we && wAddr == rAddr1) ? wData : regs[rAddr1];
    assign rData2 = (we && wAddr == rAddr2) ? wData : regs[rAddr2];

    // The write address comes registered from the execute stage
    assert property (@(posedge clk) disable iff (!rstN) we |-> !$isunknown(wAddr))
        else $error("regFile: write with unknown address");

endmodule

/* execStage.sv */
`timescale 1ns/1ps

module execStage (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         instrValid,
    input  logic                         isAlu,
    input  logic                         useImm,
    input  logic                         signExtImm,
    input  logic                         isWwd,
    input  logic                         isLoad,
    input  logic                         isStore,
    input  logic                         isBranch,
    input  logic                         regWeIn,
    input  logic [1:0]                   wAddrIn,
    input  logic [3:0]                   opcode,
    input  logic [5:0]                   func,
    input  logic [7:0]                   imm,
    input  logic [tscPkg::WordWidth-1:0] rsData,
    input  logic [tscPkg::WordWidth-1:0] rtData,
    output logic                         regWe,
    output logic [1:0]                   wAddr,
    output logic [tscPkg::WordWidth-1:0] wData,
    output logic                         outValid,
    output logic [tscPkg::WordWidth-1:0] outData,
    output logic                         memRead,
    output logic                         memWrite,
    output logic [tscPkg::WordWidth-1:0] memAddr,
    output logic [tscPkg::WordWidth-1:0] memWdata,
    output logic                         branchValid,
    output logic                         branchTaken
);

    import tscPkg::*;

    logic [3:0]           aluOp;
    logic [WordWidth-1:0] extImm;
    logic [WordWidth-1:0] opB;
    logic [WordWidth-1:0] aluY;
    logic                 aluZero;
    logic                 zeroB;
    logic                 taken;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operands and ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign extImm = signExtImm ? {{(WordWidth-8){imm[7]}}, imm} : {{(WordWidth-8){1'b0}}, imm};

    // BGZ, BLZ and WWD add zero so that rs itself comes out of the ALU
    assign zeroB = isWwd || (isBranch && (opcode == BgzOp || opcode == BlzOp));
    assign opB   = useImm ? extImm : (zeroB ? '0 : rtData);

    aluControl uAluCtrl (
        .isAlu  (isAlu),
        .opcode (opcode),
        .func   (func),
        .aluOp  (aluOp)
    );

    alu uAlu (
        .a     (rsData),
        .b     (opB),
        .aluOp (aluOp),
        .y     (aluY),
        .zero  (aluZero)
    );

    always_comb begin
        case (opcode)
            BeqOp:   taken = aluZero;
            BneOp:   taken = !aluZero;
            BgzOp:   taken = !aluY[WordWidth-1] && !aluZero;
            BlzOp:   taken = aluY[WordWidth-1];
            default: taken = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outcome registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWe       <= 1'b0;
            outValid    <= 1'b0;
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
            branchValid <= 1'b0;
        end else begin
            regWe       <= instrValid && regWeIn;
            outValid    <= instrValid && isWwd;
            memRead     <= instrValid && isLoad;
            memWrite    <= instrValid && isStore;
            branchValid <= instrValid && isBranch;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            wAddr       <= wAddrIn;
            wData       <= aluY;
            outData     <= aluY;
            memAddr     <= aluY;        // rs plus the sign-extended offset
            memWdata    <= rtData;
            branchTaken <= taken;
        end
    end

    // The decoder never marks one instruction as both load and store
    assert property (@(posedge clk) disable iff (!rstN) !(memRead && memWrite))
        else $error("execStage: load and store strobes together");

endmodule

/* tscExecCore.sv */
`timescale 1ns/1ps

module tscExecCore (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         instrValid,
    input  tscPkg::instrT                instr,
    output logic                         regWe,
    output logic [1:0]                   wAddr,
    output logic [tscPkg::WordWidth-1:0] wData,
    output logic                         outValid,
    output logic [tscPkg::WordWidth-1:0] outData,
    output logic                         memRead,
    output logic                         memWrite,
    output logic [tscPkg::WordWidth-1:0] memAddr,
    output logic [tscPkg::WordWidth-1:0] memWdata,
    output logic                         branchValid,
    output logic                         branchTaken
);

    import tscPkg::*;

    logic [1:0]           rs;
    logic [1:0]           rt;
    logic [1:0]           decWAddr;
    logic                 decRegWe;
    logic                 isAlu;
    logic                 useImm;
    logic                 signExtImm;
    logic                 isWwd;
    logic                 isLoad;
    logic                 isStore;
    logic                 isBranch;
    logic [3:0]           opcode;
    logic [5:0]           func;
    logic [7:0]           imm;
    logic [WordWidth-1:0] rsData;
    logic [WordWidth-1:0] rtData;

    instrDecoder uDec (
        .instr      (instr),
        .rs         (rs),
        .rt         (rt),
        .wAddr      (decWAddr),
        .regWe      (decRegWe),
        .isAlu      (isAlu),
        .useImm     (useImm),
        .signExtImm (signExtImm),
        .isWwd      (isWwd),
        .isLoad     (isLoad),
        .isStore    (isStore),
        .isBranch   (isBranch),
        .opcode     (opcode),
        .func       (func),
        .imm        (imm)
    );

    // Written from the registered outcome of the execute stage
    regFile uRegs (
        .clk    (clk),
        .rstN   (rstN),
        .we     (regWe),
        .rAddr1 (rs),
        .rAddr2 (rt),
        .wAddr  (wAddr),
        .wData  (wData),
        .rData1 (rsData),
        .rData2 (rtData)
    );

    execStage uExec (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .isAlu       (isAlu),
        .useImm      (useImm),
        .signExtImm  (signExtImm),
        .isWwd       (isWwd),
        .isLoad      (isLoad),
        .isStore     (isStore),
        .isBranch    (isBranch),
        .regWeIn     (decRegWe),
        .wAddrIn     (decWAddr),
        .opcode      (opcode),
        .func        (func),
        .imm         (imm),
        .rsData      (rsData),
        .rtData      (rtData),
        .regWe       (regWe),
        .wAddr       (wAddr),
        .wData       (wData),
        .outValid    (outValid),
        .outData     (outData),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .branchValid (branchValid),
        .branchTaken (branchTaken)
    );

endmodule

/* tbTscExec.sv */
`timescale 1ns/1ps

module tbTscExec;

    import tscPkg::*;

    localparam int KindNone   = 0;
    localparam int KindWrite  = 1;
    localparam int KindOut    = 2;
    localparam int KindLoad   = 3;
    localparam int KindStore  = 4;
    localparam int KindBranch = 5;
    localparam int NumInstr   = 4 + 8 + 32 + 18 + 12 + 12 + 26 + 2;  // Cycles driven after reset

    logic                 clk;
    logic                 rstN;
    logic                 instrValid;
    instrT                instr;
    logic                 regWe;
    logic [1:0]           wAddr;
    logic [WordWidth-1:0] wData;
    logic                 outValid;
    logic [WordWidth-1:0] outData;
    logic                 memRead;
    logic                 memWrite;
    logic [WordWidth-1:0] memAddr;
    logic [WordWidth-1:0] memWdata;
    logic                 branchValid;
    logic                 branchTaken;

    logic [WordWidth-1:0] shadow [NumRegs];
    integer               seed;
    int                   checks;
    int                   valueErrs;
    int                   strobeErrs;
    logic [1:0]           ra;
    logic [1:0]           rb;
    logic [1:0]           rc;
    logic [3:0]           rOp;
    logic [7:0]           immBits;

    int                   expKindQ [$];
    logic [WordWidth-1:0] expValQ [$];
    logic [WordWidth-1:0] expDataQ [$];
    logic [1:0]           expAddrQ [$];
    logic                 expTakenQ [$];
    int                   cmpKind;
    logic [WordWidth-1:0] cmpVal;
    logic [WordWidth-1:0] cmpData;
    logic [1:0]           cmpAddr;
    logic                 cmpTaken;

    tscExecCore u_dut (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .regWe       (regWe),
        .wAddr       (wAddr),
        .wData       (wData),
        .outValid    (outValid),
        .outData     (outData),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .branchValid (branchValid),
        .branchTaken (branchTaken)
    );

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction builders and random fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic instrT makeR(input logic [1:0] rs, input logic [1:0] rt,
                                    input logic [1:0] rd, input logic [5:0] fn);
        instrT w;
        w.r.opcode = RtypeOp;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.func   = fn;
        return w;
    endfunction

    function automatic instrT makeI(input logic [3:0] op, input logic [1:0] rs,
                                    input logic [1:0] rt, input logic [7:0] imm);
        instrT w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic logic [7:0] randImm();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [1:0] randReg();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int refExec(input instrT ins, output logic [WordWidth-1:0] val,
                                   output logic [WordWidth-1:0] data, output logic [1:0] addr,
                                   output logic taken);
        logic [WordWidth-1:0] a;
        logic [WordWidth-1:0] b;
        logic [WordWidth-1:0] sImm;
        int                   kind;
        a     = shadow[ins.r.rs];
        b     = shadow[ins.r.rt];
        sImm  = {{8{ins.i.imm[7]}}, ins.i.imm};
        kind  = KindNone;
        val   = '0;
        data  = b;                           // Store data is rt
        addr  = ins.i.rt;
        taken = 1'b0;
        case (ins.r.opcode)
            RtypeOp: begin
                addr = ins.r.rd;
                if (ins.r.func <= FuncShr) begin
                    kind = KindWrite;
                    case (ins.r.func[2:0])
                        3'd0:    val = a + b;
                        3'd1:    val = a - b;
                        3'd2:    val = a & b;
                        3'd3:    val = a | b;
                        3'd4:    val = ~a;
                        3'd5:    val = -a;
                        3'd6:    val = a << 1;
                        default: val = $signed(a) >>> 1;
                    endcase
                end else if (ins.r.func == FuncWwd) begin
                    kind = KindOut;
                    val  = a;
                end
            end
            AdiOp: begin
                kind = KindWrite;
                val  = a + sImm;
            end
            OriOp: begin
                kind = KindWrite;
                val  = a | {8'h00, ins.i.imm};   // Zero-extended
            end
            LwdOp: begin
                kind = KindLoad;
                val  = a + sImm;
            end
            SwdOp: begin
                kind = KindStore;
                val  = a + sImm;
            end
            BeqOp: begin
                kind  = KindBranch;
                taken = (a == b);
            end
            BneOp: begin
                kind  = KindBranch;
                taken = (a != b);
            end
            BgzOp: begin
                kind  = KindBranch;
                taken = !a[WordWidth-1] && (a != '0);
            end
            BlzOp: begin
                kind  = KindBranch;
                taken = a[WordWidth-1];
            end
            default: begin
                kind = KindNone;
            end
        endcase
        if (kind == KindWrite) begin
            shadow[addr] = val;              // The very next instruction reads the new value
        end
        return kind;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic issue(input instrT ins);
        int                   kind;
        logic [WordWidth-1:0] val;
        logic [WordWidth-1:0] data;
        logic [1:0]           addr;
        logic                 taken;
        @(negedge clk);
        kind       = refExec(ins, val, data, addr, taken);
        instrValid = 1'b1;
        instr      = ins;
        expKindQ.push_back(kind);
        expValQ.push_back(val);
        expDataQ.push_back(data);
        expAddrQ.push_back(addr);
        expTakenQ.push_back(taken);
    endtask

    task automatic idle();
        @(negedge clk);
        instrValid = 1'b0;
        instr      = '0;
        expKindQ.push_back(KindNone);
        expValQ.push_back('0);
        expDataQ.push_back('0);
        expAddrQ.push_back(2'd0);
        expTakenQ.push_back(1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks and compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic checkBit(input logic got, input logic exp, input string what,
                            input bit isStrobe);
        checks++;
        if (got !== exp) begin
            if (!isStrobe) begin
                valueErrs++;
                $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            end else if (exp) begin
                strobeErrs++;
                $display("Missing %s strobe at %0t ns", what, $time);
            end else begin
                strobeErrs++;
                $display("Unexpected %s strobe at %0t ns", what, $time);
            end
        end
    endtask

    task automatic checkWord(input logic [WordWidth-1:0] got, input logic [WordWidth-1:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            valueErrs++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkAddr(input logic [1:0] got, input logic [1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            valueErrs++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    always begin
        @(posedge clk);
        #2;                                  // Outputs have settled after the edge
        if (expKindQ.size() > 0) begin
            cmpKind  = expKindQ.pop_front();
            cmpVal   = expValQ.pop_front();
            cmpData  = expDataQ.pop_front();
            cmpAddr  = expAddrQ.pop_front();
            cmpTaken = expTakenQ.pop_front();
            checkBit(regWe, cmpKind == KindWrite, "regWe", 1'b1);
            checkBit(outValid, cmpKind == KindOut, "outValid", 1'b1);
            checkBit(memRead, cmpKind == KindLoad, "memRead", 1'b1);
            checkBit(memWrite, cmpKind == KindStore, "memWrite", 1'b1);
            checkBit(branchValid, cmpKind == KindBranch, "branchValid", 1'b1);
            case (cmpKind)
                KindWrite: begin
                    checkAddr(wAddr, cmpAddr, "wAddr");
                    checkWord(wData, cmpVal, "wData");
                end
                KindOut:    checkWord(outData, cmpVal, "outData");
                KindLoad:   checkWord(memAddr, cmpVal, "memAddr");
                KindStore: begin
                    checkWord(memAddr, cmpVal, "memAddr");
                    checkWord(memWdata, cmpData, "memWdata");
                end
                KindBranch: checkBit(branchTaken, cmpTaken, "branchTaken", 1'b0);
                default:    ;
            endcase
        end
    end

    initial begin
        #(NumInstr * 8 + 200);
        $display("Timeout: the run did not finish before the watchdog limit");
        $display("*** FAILED ***");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        seed       = 32'hd417758d;
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        checks     = 0;
        valueErrs  = 0;
        strobeErrs = 0;
        for (int k = 0; k < NumRegs; k++) begin
            shadow[k] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        checkBit(regWe, 1'b0, "regWe", 1'b1);          // Reset state of every strobe
        checkBit(outValid, 1'b0, "outValid", 1'b1);
        checkBit(memRead, 1'b0, "memRead", 1'b1);
        checkBit(memWrite, 1'b0, "memWrite", 1'b1);
        checkBit(branchValid, 1'b0, "branchValid", 1'b1);
        for (int k = 0; k < 4; k++) begin
            issue(makeR(k[1:0], 2'd0, 2'd0, FuncWwd));
        end

        // ADI then ORI, the immediate sign bit alternating
        for (int k = 0; k < 8; k++) begin
            immBits = randImm();
            issue(makeI(k < 4 ? AdiOp : OriOp, randReg(), k[1:0], {k[0], immBits[6:0]}));
        end

        for (int k = 0; k < 16; k++) begin
            issue(makeI(AdiOp, randReg(), randReg(), randImm()));
            issue(makeR(randReg(), randReg(), randReg(), {3'b000, k[2:0]}));
        end
        for (int f = 8; f < 26; f++) begin
            issue(makeR(randReg(), randReg(), randReg(), f[5:0]));   // No outcome expected
        end

        // Consumer right behind its producer
        for (int k = 0; k < 6; k++) begin
            rc = randReg();
            issue(makeI(AdiOp, randReg(), rc, randImm()));
            immBits = randImm();
            issue(makeR(rc, randReg(), randReg(), {3'b000, immBits[2:0]}));
        end

        for (int k = 0; k < 12; k++) begin
            ra = randReg();
            rb = randReg();
            if (k % 3 == 0) begin
                issue(makeI(LwdOp, ra, rb, randImm()));
            end else if (k % 3 == 1) begin
                issue(makeI(SwdOp, ra, rb, randImm()));
            end else begin
                issue(makeR(ra, rb, randReg(), FuncWwd));
            end
        end

        // Zero in r1, then all four branches on it
        issue(makeR(2'd3, 2'd3, 2'd1, FuncSub));
        idle();
        for (int k = 0; k < 4; k++) begin
            issue(makeI(k[3:0], 2'd1, 2'd1, randImm()));
        end
        for (int k = 0; k < 10; k++) begin
            issue(makeI(AdiOp, randReg(), randReg(), randImm()));
            ra  = randReg();
            rb  = (k % 4 == 0) ? ra : randReg();
            rOp = {2'b00, k[1:0]};
            issue(makeI(rOp, ra, rb, randImm()));
        end

        idle();
        idle();
        @(posedge clk);
        #3;
        $display("Checks %0d, value mismatches %0d, strobe errors %0d",
                 checks, valueErrs, strobeErrs);
        if (valueErrs + strobeErrs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
tscPkg.sv
aluControl.sv
instrDecoder.sv
alu.sv
regFile.sv
execStage.sv
tscExecCore.sv
tbTscExec.sv
